/* source/bus_pkg.sv */
// widths of the shared memory bus
// address, data and byte-enable sizes
// byte lane width derived from the above
// endianness flag used by the port multiplexer

package bus_pkg;

    // byte address width on both ports and on the bus
    localparam int ADDR_W = 32;

    // one data word, same on ports and bus
    localparam int DATA_W = 32;

    // one enable bit per byte lane
    localparam int BE_W = 4;

    // width of a single byte lane
    localparam int BYTE_W = DATA_W / BE_W;

    // bus side is little endian, core side big endian
    // 1: words and byte enables are reversed between ports and bus
    // 0: everything passes straight through
    localparam logic BUS_LITTLE_ENDIAN = 1'b1;

endpackage

/* source/arb_pkg.sv */
// arbiter FSM state encoding
// port select carried from the arbiter to the bus multiplexer

package arb_pkg;

    // encoding widths
    localparam int STATE_W = 3;
    localparam int SEL_W = 2;

    // instr_data_req: data address phase over the instruction data phase
    // data_instr_req: the other way round
    typedef enum logic [STATE_W-1:0] {
        idle,
        instr_req,
        instr_data_req,
        instr_wait,
        data_req,
        data_instr_req,
        data_wait
    } arb_state_t;

    // owner of the current address phase
    typedef enum logic [SEL_W-1:0] {
        sel_none,
        sel_instr,
        sel_data
    } port_sel_t;

endpackage

/* source/request_arbiter.sv */
// instruction/data request arbiter
// seven-state FSM, data port has priority
// overlaps a second address phase with the running data phase
// aborts instruction fetches withdrawn before bus acceptance

`timescale 1ns/1ps

module request_arbiter (
    input  logic               CLK,
    input  logic               arst_n,
    input  logic               i_ren,
    input  logic               d_ren,
    input  logic               d_wen,
    input  logic               mem_busy,
    output arb_pkg::port_sel_t addr_sel,
    output logic               i_busy,
    output logic               d_busy
);

    arb_pkg::arb_state_t state;
    arb_pkg::arb_state_t next_state;

    // any data access, read or write
    logic d_req;

    assign d_req = d_ren | d_wen;

    // state register
    always_ff @(posedge CLK, negedge arst_n) begin
        if (!arst_n) begin
            state <= arb_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    // next state
    always_comb begin
        next_state = state;
        case (state)
            arb_pkg::idle: begin
                // data wins a tie
                if (d_req) begin
                    next_state = arb_pkg::data_req;
                end else if (i_ren) begin
                    next_state = arb_pkg::instr_req;
                end
            end

            arb_pkg::instr_req: begin
                // fetch dropped before acceptance, interrupt case
                if (!i_ren) begin
                    next_state = arb_pkg::idle;
                end else if (!mem_busy) begin
                    // fetch address accepted this cycle
                    if (d_req) begin
                        next_state = arb_pkg::instr_data_req;
                    end else begin
                        next_state = arb_pkg::instr_wait;
                    end
                end
            end

            arb_pkg::instr_data_req: begin
                // fetch data phase ends, data address taken in same cycle
                if (!mem_busy) begin
                    next_state = arb_pkg::data_wait;
                end
            end

            arb_pkg::instr_wait: begin
                if (!mem_busy) begin
                    if (d_req) begin
                        next_state = arb_pkg::data_req;
                    end else begin
                        next_state = arb_pkg::idle;
                    end
                end else if (d_req) begin
                    // start the data address phase during the fetch data phase
                    next_state = arb_pkg::instr_data_req;
                end
            end

            arb_pkg::data_req: begin
                if (!mem_busy) begin
                    if (i_ren) begin
                        next_state = arb_pkg::data_instr_req;
                    end else begin
                        next_state = arb_pkg::data_wait;
                    end
                end
            end

            arb_pkg::data_instr_req: begin
                if (!mem_busy) begin
                    // fetch withdrawn, so no address phase went out
                    if (!i_ren) begin
                        next_state = arb_pkg::idle;
                    end else begin
                        next_state = arb_pkg::instr_wait;
                    end
                end
            end

            arb_pkg::data_wait: begin
                if (!mem_busy) begin
                    if (i_ren) begin
                        next_state = arb_pkg::instr_req;
                    end else begin
                        next_state = arb_pkg::idle;
                    end
                end else if (i_ren) begin
                    next_state = arb_pkg::data_instr_req;
                end
            end

            default: begin
                next_state = arb_pkg::idle;
            end
        endcase
    end

    // address phase owner and port busy
    // only the port in its data phase sees mem_busy
    always_comb begin
        addr_sel = arb_pkg::sel_none;
        i_busy   = 1'b1;
        d_busy   = 1'b1;
        case (state)
            arb_pkg::instr_req: begin
                addr_sel = arb_pkg::sel_instr;
            end
            arb_pkg::instr_data_req: begin
                addr_sel = arb_pkg::sel_data;
                i_busy   = mem_busy;
            end
            arb_pkg::instr_wait: begin
                i_busy = mem_busy;
            end
            arb_pkg::data_req: begin
                addr_sel = arb_pkg::sel_data;
            end
            arb_pkg::data_instr_req: begin
                addr_sel = arb_pkg::sel_instr;
                d_busy   = mem_busy;
            end
            arb_pkg::data_wait: begin
                d_busy = mem_busy;
            end
            default: begin
                addr_sel = arb_pkg::sel_none;
            end
        endcase
    end

endmodule

/* source/master_port_mux.sv */
// bus multiplexer for the instruction and data ports
// steers the selected address phase onto the memory bus
// byte swap of write data, read data and byte enables

`timescale 1ns/1ps

module master_port_mux (
    input  arb_pkg::port_sel_t          addr_sel,
    input  logic                        i_ren,
    input  logic [bus_pkg::ADDR_W-1:0]  i_addr,
    input  logic                        d_ren,
    input  logic                        d_wen,
    input  logic [bus_pkg::ADDR_W-1:0]  d_addr,
    input  logic [bus_pkg::DATA_W-1:0]  d_wdata,
    input  logic [bus_pkg::BE_W-1:0]    d_byte_en,
    input  logic [bus_pkg::DATA_W-1:0]  mem_rdata,
    output logic                        mem_ren,
    output logic                        mem_wen,
    output logic [bus_pkg::ADDR_W-1:0]  mem_addr,
    output logic [bus_pkg::DATA_W-1:0]  mem_wdata,
    output logic [bus_pkg::BE_W-1:0]    mem_byte_en,
    output logic [bus_pkg::DATA_W-1:0]  i_rdata,
    output logic [bus_pkg::DATA_W-1:0]  d_rdata
);

    // core side values after the endian stage
    logic [bus_pkg::DATA_W-1:0] bus_wdata;
    logic [bus_pkg::DATA_W-1:0] core_rdata;
    logic [bus_pkg::BE_W-1:0]   bus_be;

    // byte lane b takes lane BE_W-1-b
    function automatic logic [bus_pkg::DATA_W-1:0] swap_bytes(
        input logic [bus_pkg::DATA_W-1:0] word
    );
        logic [bus_pkg::DATA_W-1:0] swapped;
        for (int b = 0; b < bus_pkg::BE_W; b++) begin
            swapped[b*bus_pkg::BYTE_W +: bus_pkg::BYTE_W] =
                word[(bus_pkg::BE_W-1-b)*bus_pkg::BYTE_W +: bus_pkg::BYTE_W];
        end
        return swapped;
    endfunction

    // enables follow their bytes, so plain bit reversal
    function automatic logic [bus_pkg::BE_W-1:0] swap_enables(
        input logic [bus_pkg::BE_W-1:0] be
    );
        logic [bus_pkg::BE_W-1:0] swapped;
        for (int b = 0; b < bus_pkg::BE_W; b++) begin
            swapped[b] = be[bus_pkg::BE_W-1-b];
        end
        return swapped;
    endfunction

    generate
        if (bus_pkg::BUS_LITTLE_ENDIAN == 1'b1) begin : g_le_bus
            assign bus_wdata  = swap_bytes(d_wdata);
            assign core_rdata = swap_bytes(mem_rdata);
            assign bus_be     = swap_enables(d_byte_en);
        end else begin : g_be_bus
            assign bus_wdata  = d_wdata;
            assign core_rdata = mem_rdata;
            assign bus_be     = d_byte_en;
        end
    endgenerate

    // address phase fields, byte enables travel with the address
    always_comb begin
        mem_ren     = 1'b0;
        mem_wen     = 1'b0;
        mem_addr    = '0;
        mem_byte_en = bus_be;
        case (addr_sel)
            arb_pkg::sel_instr: begin
                // fetches never write and read the full word
                mem_ren     = i_ren;
                mem_addr    = i_addr;
                mem_byte_en = '1;
            end
            arb_pkg::sel_data: begin
                mem_ren  = d_ren;
                mem_wen  = d_wen;
                mem_addr = d_addr;
            end
            default: begin
                mem_ren = 1'b0;
            end
        endcase
    end

    // data port holds wdata through its data phase
    assign mem_wdata = bus_wdata;

    // both ports see the read word, busy says whose it is
    assign i_rdata = core_rdata;
    assign d_rdata = core_rdata;

endmodule

/* source/memory_controller.sv */
// memory controller top level
// instruction fetch port and data load/store port
// arbiter FSM plus bus multiplexer onto one pipelined memory bus

`timescale 1ns/1ps

module memory_controller (
    input  logic                        CLK,
    input  logic                        arst_n,
    // instruction fetch port
    input  logic                        i_ren,
    input  logic [bus_pkg::ADDR_W-1:0]  i_addr,
    output logic [bus_pkg::DATA_W-1:0]  i_rdata,
    output logic                        i_busy,
    // data load/store port
    input  logic                        d_ren,
    input  logic                        d_wen,
    input  logic [bus_pkg::ADDR_W-1:0]  d_addr,
    input  logic [bus_pkg::DATA_W-1:0]  d_wdata,
    input  logic [bus_pkg::BE_W-1:0]    d_byte_en,
    output logic [bus_pkg::DATA_W-1:0]  d_rdata,
    output logic                        d_busy,
    // pipelined memory bus
    output logic                        mem_ren,
    output logic                        mem_wen,
    output logic [bus_pkg::ADDR_W-1:0]  mem_addr,
    output logic [bus_pkg::DATA_W-1:0]  mem_wdata,
    output logic [bus_pkg::BE_W-1:0]    mem_byte_en,
    input  logic [bus_pkg::DATA_W-1:0]  mem_rdata,
    input  logic                        mem_busy
);

    // which port owns the address phase
    arb_pkg::port_sel_t addr_sel;

    // FSM, also owns both busy outputs
    request_arbiter u_arbiter (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .i_ren    (i_ren),
        .d_ren    (d_ren),
        .d_wen    (d_wen),
        .mem_busy (mem_busy),
        .addr_sel (addr_sel),
        .i_busy   (i_busy),
        .d_busy   (d_busy)
    );

    // combinational steering and endian swap
    master_port_mux u_port_mux (
        .addr_sel    (addr_sel),
        .i_ren       (i_ren),
        .i_addr      (i_addr),
        .d_ren       (d_ren),
        .d_wen       (d_wen),
        .d_addr      (d_addr),
        .d_wdata     (d_wdata),
        .d_byte_en   (d_byte_en),
        .mem_rdata   (mem_rdata),
        .mem_ren     (mem_ren),
        .mem_wen     (mem_wen),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_byte_en (mem_byte_en),
        .i_rdata     (i_rdata),
        .d_rdata     (d_rdata)
    );

endmodule

/* tb/memory_controller_checker.sv */
// protocol assertions bound to the memory controller
// exclusive ren/wen, one port completing per cycle
// reset and idle values, fetches never write on the bus

`timescale 1ns/1ps

module memory_controller_checker (
    input logic               CLK,
    input logic               arst_n,
    input logic               i_ren,
    input logic               d_ren,
    input logic               d_wen,
    input logic               mem_ren,
    input logic               mem_wen,
    input logic               i_busy,
    input logic               d_busy,
    input arb_pkg::port_sel_t addr_sel
);

    // failed assertions so far, polled by the testbench
    int fail_count = 0;

    // set once either port has asked for anything
    logic seen_req;

    always @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            seen_req <= 1'b0;
        end else if (i_ren || d_ren || d_wen) begin
            seen_req <= 1'b1;
        end
    end

    // an access is a read or a write, never both
    a_ren_wen_exclusive: assert property (
        @(posedge CLK) disable iff (!arst_n) !(mem_ren && mem_wen)
    ) else begin
        $error("mem_ren and mem_wen high in the same cycle");
        fail_count++;
    end

    // only one data phase ends per cycle
    a_one_port_done: assert property (
        @(posedge CLK) disable iff (!arst_n) i_busy || d_busy
    ) else begin
        $error("i_busy and d_busy low in the same cycle");
        fail_count++;
    end

    a_reset_values: assert property (
        @(posedge CLK) !arst_n |-> !mem_ren && !mem_wen && i_busy && d_busy
    ) else begin
        $error("bus or port outputs wrong during reset");
        fail_count++;
    end

    // quiet bus and busy ports until the first request
    a_idle_until_request: assert property (
        @(posedge CLK) disable iff (!arst_n)
        !seen_req |-> !mem_ren && !mem_wen && i_busy && d_busy
    ) else begin
        $error("controller left idle before any request");
        fail_count++;
    end

    a_fetch_never_writes: assert property (
        @(posedge CLK) disable iff (!arst_n) addr_sel == arb_pkg::sel_instr |-> !mem_wen
    ) else begin
        $error("write strobe driven during a fetch address phase");
        fail_count++;
    end

endmodule

/* tb/tb_bus_slave.sv */
// pipelined memory bus model for the testbench
// one access in its data phase, 0 to 3 wait states each
// words live in the testbench memory array, byte enables applied on writes

`timescale 1ns/1ps

module tb_bus_slave (
    input  logic                       CLK,
    input  logic                       arst_n,
    input  logic                       mem_ren,
    input  logic                       mem_wen,
    input  logic [bus_pkg::ADDR_W-1:0] mem_addr,
    input  logic [bus_pkg::DATA_W-1:0] mem_wdata,
    input  logic [bus_pkg::BE_W-1:0]   mem_byte_en,
    input  logic [1:0]                 wait_cycles,
    output logic [bus_pkg::DATA_W-1:0] mem_rdata,
    output logic                       mem_busy,
    output int                         accept_count
);

    // access in its data phase
    logic                     pending;
    logic                     pend_write;
    logic [5:0]               pend_idx;
    logic [bus_pkg::BE_W-1:0] pend_be;
    logic [1:0]               wait_left;
    logic                     accept;

    // stalled until the wait states are used up
    assign mem_busy = pending && (wait_left != 2'd0);
    // address phase taken whenever the bus is not stalled
    assign accept = (mem_ren || mem_wen) && !mem_busy;
    // read word only matters in the last data phase cycle
    assign mem_rdata = (pending && !pend_write) ? tb_memory_controller.mem[pend_idx] : '0;

    always @(posedge CLK or negedge arst_n) begin : bus_step
        logic [bus_pkg::DATA_W-1:0] word;
        if (!arst_n) begin
            pending      <= 1'b0;
            pend_write   <= 1'b0;
            pend_idx     <= '0;
            pend_be      <= '0;
            wait_left    <= '0;
            accept_count <= 0;
        end else begin
            if (pending && wait_left == 2'd0) begin
                // data phase ends here, write lands on the enabled lanes
                if (pend_write) begin
                    word = tb_memory_controller.mem[pend_idx];
                    for (int b = 0; b < bus_pkg::BE_W; b++) begin
                        if (pend_be[b]) begin
                            word[b*8 +: 8] = mem_wdata[b*8 +: 8];
                        end
                    end
                    tb_memory_controller.mem[pend_idx] = word;
                end
                pending <= 1'b0;
            end else if (pending) begin
                wait_left <= wait_left - 2'd1;
            end
            // next address phase may overlap the ending data phase
            if (accept) begin
                pending      <= 1'b1;
                pend_write   <= mem_wen;
                pend_idx     <= mem_addr[7:2];
                pend_be      <= mem_byte_en;
                wait_left    <= wait_cycles;
                accept_count <= accept_count + 1;
            end
        end
    end

endmodule

/* tb/tb_memory_controller.sv */
// memory controller testbench
// clock, reset, LCG stimulus and a core side reference memory
// directed and random port accesses checked by immediate assertions
// bus model, bound protocol checker, watchdog and final verdict

`timescale 1ns/1ps

module tb_memory_controller;

    localparam int MEM_WORDS = 64;
    localparam int N_RANDOM = 24;
    // directed accesses plus up to two per random step
    localparam int NUM_TRANS = 12 + 2 * N_RANDOM;
    localparam int WATCHDOG_CYCLES = NUM_TRANS * 12 + 50;
    localparam logic [31:0] SEED = 32'h70a54ee4;

    logic                       CLK;
    logic                       arst_n;
    logic                       i_ren;
    logic [bus_pkg::ADDR_W-1:0] i_addr;
    logic [bus_pkg::DATA_W-1:0] i_rdata;
    logic                       i_busy;
    logic                       d_ren;
    logic                       d_wen;
    logic [bus_pkg::ADDR_W-1:0] d_addr;
    logic [bus_pkg::DATA_W-1:0] d_wdata;
    logic [bus_pkg::BE_W-1:0]   d_byte_en;
    logic [bus_pkg::DATA_W-1:0] d_rdata;
    logic                       d_busy;
    logic                       mem_ren;
    logic                       mem_wen;
    logic [bus_pkg::ADDR_W-1:0] mem_addr;
    logic [bus_pkg::DATA_W-1:0] mem_wdata;
    logic [bus_pkg::BE_W-1:0]   mem_byte_en;
    logic [bus_pkg::DATA_W-1:0] mem_rdata;
    logic                       mem_busy;
    // little endian bus side words written by the bus model
    logic [31:0] mem [MEM_WORDS];
    // same words as the core sees them
    logic [31:0] ref_mem [MEM_WORDS];
    logic [31:0] stim_state;
    logic [31:0] wait_state;
    logic [1:0]  wait_cycles;
    int          accept_count;

    memory_controller u_dut (.*);

    tb_bus_slave u_slave (.*);

    bind memory_controller memory_controller_checker u_checker (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .i_ren    (i_ren),
        .d_ren    (d_ren),
        .d_wen    (d_wen),
        .mem_ren  (mem_ren),
        .mem_wen  (mem_wen),
        .i_busy   (i_busy),
        .d_busy   (d_busy),
        .addr_sel (addr_sel)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    task automatic stop_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_state = lcg_step(stim_state);
        return stim_state;
    endfunction

    // upper LCG bits since the low ones repeat too soon
    function automatic logic [31:0] word_addr(input logic [31:0] r);
        return {24'h0, r[23:18], 2'b00};
    endfunction

    // core byte 0 sits in the top bus lane
    function automatic logic [31:0] reverse_bytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // core side write where enable bit b covers core byte b
    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  be
    );
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic data_access(
        input  logic        write,
        input  logic [31:0] addr,
        input  logic [31:0] wdata,
        input  logic [3:0]  be,
        output time         done_at
    );
        logic [31:0] expected;
        @(posedge CLK);
        #10;
        d_ren     = !write;
        d_wen     = write;
        d_addr    = addr;
        d_wdata   = wdata;
        d_byte_en = be;
        @(negedge CLK);
        while (d_busy) begin
            @(negedge CLK);
        end
        done_at = $time;
        if (write) begin
            ref_mem[addr[7:2]] = merge_bytes(ref_mem[addr[7:2]], wdata, be);
        end else begin
            expected = ref_mem[addr[7:2]];
            assert (d_rdata == expected) else begin
                $display("error %0t: data read at %h returned %h, expected %h",
                    $time, addr, d_rdata, expected);
                stop_with_failure();
            end
        end
        @(posedge CLK);
        #10;
        d_ren = 1'b0;
        d_wen = 1'b0;
        // bus word must hold the write in little endian order
        if (write) begin
            expected = reverse_bytes(ref_mem[addr[7:2]]);
            assert (mem[addr[7:2]] == expected) else begin
                $display("error %0t: bus word at %h is %h, expected %h",
                    $time, addr, mem[addr[7:2]], expected);
                stop_with_failure();
            end
        end
    endtask

    task automatic fetch(input logic [31:0] addr, output time done_at);
        logic [31:0] expected;
        @(posedge CLK);
        #10;
        i_ren  = 1'b1;
        i_addr = addr;
        @(negedge CLK);
        while (i_busy) begin
            @(negedge CLK);
        end
        done_at = $time;
        expected = ref_mem[addr[7:2]];
        assert (i_rdata == expected) else begin
            $display("error %0t: fetch at %h returned %h, expected %h",
                $time, addr, i_rdata, expected);
            stop_with_failure();
        end
        @(posedge CLK);
        #10;
        i_ren = 1'b0;
    endtask

    // wait states for the bus model from a second LCG stream
    always @(posedge CLK) begin
        #10;
        wait_state = lcg_step(wait_state);
        wait_cycles = wait_state[31:30];
    end

    // a failed bound assertion ends the run at once
    initial begin
        wait (u_dut.u_checker.fail_count != 0);
        $display("a bound protocol assertion failed, see the message above");
        stop_with_failure();
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("timeout: accesses did not finish within %0d cycles", WATCHDOG_CYCLES);
        stop_with_failure();
    end

    initial begin
        int          accepted;
        time         d_done;
        time         i_done;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] a2;
        logic [31:0] wd;
        arst_n      = 1'b0;
        i_ren       = 1'b0;
        i_addr      = '0;
        d_ren       = 1'b0;
        d_wen       = 1'b0;
        d_addr      = '0;
        d_wdata     = '0;
        d_byte_en   = '0;
        wait_cycles = 2'd0;
        stim_state  = SEED;
        wait_state  = ~SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (i * 32'h9e3779b1) ^ 32'h5a0f3cc3;
            ref_mem[i] = reverse_bytes(mem[i]);
        end
        repeat (4) @(posedge CLK);
        #10;
        arst_n = 1'b1;

        // quiet after reset
        repeat (3) begin
            @(negedge CLK);
            assert (!mem_ren && !mem_wen && i_busy && d_busy) else begin
                $display("error %0t: controller not idle after reset", $time);
                stop_with_failure();
            end
        end

        // full and partial writes with read back and an untouched word
        data_access(1'b1, 32'h40, 32'h1122_3344, 4'hf, d_done);
        data_access(1'b0, 32'h40, '0, '0, d_done);
        data_access(1'b1, 32'h40, 32'haabb_ccdd, 4'b0101, d_done);
        data_access(1'b0, 32'h40, '0, '0, d_done);
        data_access(1'b0, 32'h9c, '0, '0, d_done);
        fetch(32'h20, i_done);

        // same cycle request with data first and the fetch overlapped
        fork
            data_access(1'b0, 32'h80, '0, '0, d_done);
            fetch(32'hc4, i_done);
        join
        assert (d_done < i_done) else begin
            $display("error %0t: data done at %0t, not before fetch at %0t",
                $time, d_done, i_done);
            stop_with_failure();
        end

        // data request arrives while the fetch is pending
        fork
            fetch(32'h10, i_done);
            begin
                @(posedge CLK);
                data_access(1'b1, 32'h14, 32'hcafe_f00d, 4'b1100, d_done);
            end
        join
        assert (i_done < d_done) else begin
            $display("error %0t: fetch done at %0t, not before data at %0t",
                $time, i_done, d_done);
            stop_with_failure();
        end

        // fetch dropped one cycle after it was raised
        accepted = accept_count;
        @(posedge CLK);
        #10;
        i_ren  = 1'b1;
        i_addr = word_addr(next_rand());
        @(posedge CLK);
        #10;
        i_ren = 1'b0;
        // aborted fetch never completes on the instruction port
        repeat (2) begin
            @(negedge CLK);
            assert (i_busy) else begin
                $display("error %0t: withdrawn fetch completed on the instruction port",
                    $time);
                stop_with_failure();
            end
        end
        assert (accept_count == accepted) else begin
            $display("error %0t: withdrawn fetch gave %0d accepted address phases",
                $time, accept_count - accepted);
            stop_with_failure();
        end
        data_access(1'b0, 32'h14, '0, '0, d_done);

        for (int n = 0; n < N_RANDOM; n++) begin
            r  = next_rand();
            a  = word_addr(next_rand());
            a2 = word_addr(next_rand());
            wd = next_rand();
            case (r[31:30])
                2'd0: data_access(1'b0, a, wd, r[27:24], d_done);
                2'd1: data_access(1'b1, a, wd, r[27:24], d_done);
                2'd2: fetch(a, i_done);
                default: begin
                    fork
                        data_access(r[29], a, wd, r[27:24], d_done);
                        fetch(a2, i_done);
                    join
                end
            endcase
        end

        repeat (2) @(posedge CLK);
        if (u_dut.u_checker.fail_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

/* memory_controller.f */
source/bus_pkg.sv
source/arb_pkg.sv
source/request_arbiter.sv
source/master_port_mux.sv
source/memory_controller.sv
tb/memory_controller_checker.sv
tb/tb_bus_slave.sv
tb/tb_memory_controller.sv
